// ==== verif/axis_converter_tests.txt ====
# length(decimal) first_byte(hex) gaps(1 random input gaps, 0 back-to-back)
# Byte k of a packet is first_byte + k, modulo 256
1    a5 1
8    00 1
32   10 1
33   f0 1
1500 3c 1
64   01 0
9    80 0
31   fe 0
7    11 0
40   c3 0
200  22 1
65   ff 1
96   40 0
1024 7f 1

// ==== build.f ====
+incdir+hw
hw/axis_conv_pkg.sv
hw/axis_fallthrough_fifo.sv
hw/axis_len_tagger.sv
hw/axis_downsizer.sv
hw/axis_converter_top.sv
verif/axis_converter_props.sv
verif/axis_converter_checker.sv
verif/axis_converter_tb.sv

// ==== Bender.yml ====
package:
  name: axis_converter

export_include_dirs:
  - hw

sources:
  - hw/axis_conv_pkg.sv
  - hw/axis_fallthrough_fifo.sv
  - hw/axis_len_tagger.sv
  - hw/axis_downsizer.sv
  - hw/axis_converter_top.sv
  - target: test
    files:
      - verif/axis_converter_props.sv
      - verif/axis_converter_checker.sv
      - verif/axis_converter_tb.sv

// ==== verif/axis_converter_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the 256-to-64 bit stream converter: packets from a file,
// random input gaps and random output back-pressure
////////////////////////////////////////////////////////////////////////////

module axis_converter_tb;

   logic                   axi_aclk;
   logic                   axi_resetn;
   axis_conv_pkg::s_data_t s_axis_tdata;
   axis_conv_pkg::s_strb_t s_axis_tstrb;
   logic                   s_axis_tvalid;
   logic                   s_axis_tready;
   logic                   s_axis_tlast;
   axis_conv_pkg::m_data_t m_axis_tdata;
   axis_conv_pkg::m_strb_t m_axis_tstrb;
   axis_conv_pkg::user_t   m_axis_tuser;
   logic                   m_axis_tvalid;
   logic                   m_axis_tready;
   logic                   m_axis_tlast;

   int   len_q[$];
   int   first_q[$];
   int   gaps_q[$];
   int   cycle_limit;
   int   cycles;
   logic limit_known = 1'b0;

   axis_converter_top dut0 (.*);

   axis_converter_checker chk0 (.*);

   initial begin
      axi_aclk = 1'b0;
      forever #10 axi_aclk = ~axi_aclk;
   end

   always @(posedge axi_aclk) begin
      m_axis_tready <= ($urandom_range(3) != 0);  // Ready about 3 cycles in 4
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   task automatic load_tests();
      int    fd;
      int    len;
      int    first;
      int    gaps;
      int    total;
      string line;
      total = 0;
      fd = $fopen("verif/axis_converter_tests.txt", "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%d %h %d", len, first, gaps) == 3) begin
               len_q.push_back(len);
               first_q.push_back(first);
               gaps_q.push_back(gaps);
               total += (len + 7) / 8 + (len + 31) / 32;  // Output beats plus input words
            end
         end
         $fclose(fd);
      end
      cycle_limit = 8 * total + 200;
      limit_known = 1'b1;
   endtask

   task automatic send_packet(input int len, input int first, input int gaps);
      axis_conv_pkg::s_data_t data;
      axis_conv_pkg::s_strb_t strb;
      int                     nwords;
      int                     idx;
      nwords = (len + 31) / 32;
      for (int w = 0; w < nwords; w++) begin
         if (gaps != 0 && $urandom_range(3) == 0) begin
            s_axis_tvalid <= 1'b0;
            repeat ($urandom_range(3, 1)) @(posedge axi_aclk);
         end
         data = '0;
         strb = '0;
         for (int b = 0; b < 32; b++) begin
            idx = w * 32 + b;
            if (idx < len) begin
               data[b*8 +: 8] = 8'(first + idx);
               strb[b]        = 1'b1;
            end
         end
         s_axis_tdata  <= data;
         s_axis_tstrb  <= strb;
         s_axis_tlast  <= (w == nwords - 1);
         s_axis_tvalid <= 1'b1;
         @(posedge axi_aclk);
         while (!s_axis_tready) @(posedge axi_aclk);  // Hold until accepted
      end
   endtask

   initial begin
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b0;
      void'($urandom(43920));
      load_tests();
      if (len_q.size() == 0) begin
         $display("No packets could be read from verif/axis_converter_tests.txt");
         $display("Testbench failed");
         $finish;
      end else begin
         repeat (10) @(posedge axi_aclk);
         axi_resetn <= 1'b1;
         repeat (2) @(posedge axi_aclk);
         foreach (len_q[i]) begin
            chk0.expect_packet(len_q[i], first_q[i]);
            send_packet(len_q[i], first_q[i], gaps_q[i]);
         end
         s_axis_tvalid <= 1'b0;
         s_axis_tlast  <= 1'b0;
         while (chk0.pending() != 0) @(posedge axi_aclk);
         repeat (20) @(posedge axi_aclk);  // Room for stray beats
         $display("Errors: %0d value, %0d framing, %0d assertion",
                  chk0.value_errors, chk0.frame_errors, dut0.props0.fail_count);
         if (chk0.value_errors == 0 && chk0.frame_errors == 0 &&
             dut0.props0.fail_count == 0) begin
            $display("Testbench passed");
         end else begin
            $display("Testbench failed");
         end
         $finish;
      end
   end

   // Watchdog
   initial begin
      cycles = 0;
      wait (limit_known);
      while (cycles < cycle_limit) begin
         @(posedge axi_aclk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the DUT hung with %0d packets never delivered",
               cycles, chk0.pending());
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== verif/axis_converter_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Output monitor: rebuilds each expected packet and compares every beat
////////////////////////////////////////////////////////////////////////////

module axis_converter_checker (
   input logic                   axi_aclk,
   input logic                   axi_resetn,
   input logic                   s_axis_tvalid,
   input logic                   s_axis_tready,
   input logic                   s_axis_tlast,
   input axis_conv_pkg::m_data_t m_axis_tdata,
   input axis_conv_pkg::m_strb_t m_axis_tstrb,
   input axis_conv_pkg::user_t   m_axis_tuser,
   input logic                   m_axis_tvalid,
   input logic                   m_axis_tready,
   input logic                   m_axis_tlast
);

   int   len_q[$];
   int   first_q[$];
   int   beat_idx;
   int   value_errors = 0;
   int   frame_errors = 0;
   logic pkt_accepted;  // A whole input packet has gone in

   task automatic expect_packet(input int len, input int first);
      len_q.push_back(len);
      first_q.push_back(first);
   endtask

   function automatic int pending();
      return len_q.size();
   endfunction

   task automatic value_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
      value_errors++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
   endtask

   task automatic check_beat();
      axis_conv_pkg::m_data_t exp_data;
      axis_conv_pkg::m_data_t got_data;
      axis_conv_pkg::m_strb_t exp_strb;
      axis_conv_pkg::user_t   exp_user;
      logic                   exp_last;
      int                     base;
      int                     nbytes;
      if (len_q.size() == 0) begin
         frame_errors++;
         $display("Extra output beat at time %0t with no packet outstanding", $time);
         return;
      end
      base     = beat_idx * 8;
      nbytes   = (len_q[0] - base < 8) ? len_q[0] - base : 8;
      exp_last = (base + 8 >= len_q[0]);
      exp_data = '0;
      got_data = '0;
      exp_strb = '0;
      for (int b = 0; b < nbytes; b++) begin
         exp_data[b*8 +: 8] = 8'(first_q[0] + base + b);
         got_data[b*8 +: 8] = m_axis_tdata[b*8 +: 8];  // Only strobed bytes count
         exp_strb[b]        = 1'b1;
      end
      if (got_data !== exp_data) value_mismatch("m_axis_tdata", exp_data, got_data);
      if (m_axis_tstrb !== exp_strb) value_mismatch("m_axis_tstrb", exp_strb, m_axis_tstrb);
      if (m_axis_tlast !== exp_last) value_mismatch("m_axis_tlast", exp_last, m_axis_tlast);
      if (beat_idx == 0) begin
         exp_user        = '0;
         exp_user[15:0]  = 16'(len_q[0]);
         exp_user[23:16] = 8'd1;  // Source port
         exp_user[31:24] = 8'd2;  // Destination port
         if (m_axis_tuser !== exp_user) value_mismatch("m_axis_tuser", exp_user, m_axis_tuser);
      end
      if (exp_last) begin
         void'(len_q.pop_front());
         void'(first_q.pop_front());
         beat_idx = 0;
      end else begin
         beat_idx++;
      end
   endtask

   always @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         beat_idx     = 0;
         pkt_accepted = 1'b0;
      end else begin
         if (m_axis_tvalid === 1'b1 && !pkt_accepted) begin
            frame_errors++;
            $display("m_axis_tvalid rose at time %0t before any packet was fully accepted",
                     $time);
         end
         if (m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) check_beat();
         if (s_axis_tvalid && s_axis_tready && s_axis_tlast) pkt_accepted = 1'b1;
      end
   end

endmodule

// ==== verif/axis_converter_props.sv ====
////////////////////////////////////////////////////////////////////////////
// Stream protocol assertions on the converter's master port
////////////////////////////////////////////////////////////////////////////

module axis_converter_props (
   input logic                   axi_aclk,
   input logic                   axi_resetn,
   input axis_conv_pkg::m_data_t m_axis_tdata,
   input axis_conv_pkg::m_strb_t m_axis_tstrb,
   input axis_conv_pkg::user_t   m_axis_tuser,
   input logic                   m_axis_tvalid,
   input logic                   m_axis_tready,
   input logic                   m_axis_tlast
);

   logic in_reset;        // Reset seen at the previous edge
   int   fail_count = 0;  // Failed assertions so far

   always_ff @(posedge axi_aclk) begin
      in_reset <= ~axi_resetn;
   end

   valid_low_in_reset: assert property (@(posedge axi_aclk)
      in_reset && !axi_resetn |-> !m_axis_tvalid)
      else begin
         $error("m_axis_tvalid high during reset");
         fail_count++;
      end

   hold_while_stalled: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
      $stable(m_axis_tstrb) && $stable(m_axis_tlast) && $stable(m_axis_tuser))
      else begin
         $error("Master beat changed while stalled");
         fail_count++;
      end

   strb_nonzero: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid |-> m_axis_tstrb != '0)
      else begin
         $error("Master beat offered with no strobe set");
         fail_count++;
      end

endmodule

bind axis_converter_top axis_converter_props props0 (
   .axi_aclk      (axi_aclk),
   .axi_resetn    (axi_resetn),
   .m_axis_tdata  (m_axis_tdata),
   .m_axis_tstrb  (m_axis_tstrb),
   .m_axis_tuser  (m_axis_tuser),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready),
   .m_axis_tlast  (m_axis_tlast)
);

// ==== hw/axis_converter_top.sv ====
////////////////////////////////////////////////////////////////////////////
// 256-to-64 bit AXI4-Stream converter with per-packet length metadata
////////////////////////////////////////////////////////////////////////////

`include "axis_conv_params.svh"

module axis_converter_top (
   input  logic                   axi_aclk,
   input  logic                   axi_resetn,
   // Slave stream
   input  axis_conv_pkg::s_data_t s_axis_tdata,
   input  axis_conv_pkg::s_strb_t s_axis_tstrb,
   input  logic                   s_axis_tvalid,
   output logic                   s_axis_tready,
   input  logic                   s_axis_tlast,
   // Master stream
   output axis_conv_pkg::m_data_t m_axis_tdata,
   output axis_conv_pkg::m_strb_t m_axis_tstrb,
   output axis_conv_pkg::user_t   m_axis_tuser,
   output logic                   m_axis_tvalid,
   input  logic                   m_axis_tready,
   output logic                   m_axis_tlast
);

   localparam int IN_W = `AXC_S_DATA_W + `AXC_S_DATA_W/8 + 1;  // last, strb, data

   logic                    word_acc;
   logic                    in_nearly_full;
   logic                    fifo_empty;
   logic                    fifo_pop;
   logic                    fifo_last;
   axis_conv_pkg::s_data_t  fifo_data;
   axis_conv_pkg::s_strb_t  fifo_strb;
   axis_conv_pkg::pkt_len_t meta_len;
   logic                    meta_empty;
   logic                    meta_full;
   logic                    meta_pop;

   assign s_axis_tready = ~in_nearly_full & ~meta_full;
   assign word_acc      = s_axis_tvalid & s_axis_tready;  // Shared by FIFO and tagger

   axis_fallthrough_fifo #(
      .WIDTH  (IN_W),
      .ADDR_W (`AXC_IN_FIFO_AW)
   ) in_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (word_acc),
      .din         ({s_axis_tlast, s_axis_tstrb, s_axis_tdata}),
      .rd_en       (fifo_pop),
      .dout        ({fifo_last, fifo_strb, fifo_data}),
      .empty       (fifo_empty),
      .nearly_full (in_nearly_full)
   );

   axis_len_tagger tagger (
      .axi_aclk     (axi_aclk),
      .axi_resetn   (axi_resetn),
      .word_acc     (word_acc),
      .s_axis_tstrb (s_axis_tstrb),
      .s_axis_tlast (s_axis_tlast),
      .meta_pop     (meta_pop),
      .meta_len     (meta_len),
      .meta_empty   (meta_empty),
      .meta_full    (meta_full)
   );

   axis_downsizer downsizer (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .fifo_data     (fifo_data),
      .fifo_strb     (fifo_strb),
      .fifo_last     (fifo_last),
      .fifo_empty    (fifo_empty),
      .fifo_pop      (fifo_pop),
      .meta_len      (meta_len),
      .meta_empty    (meta_empty),
      .meta_pop      (meta_pop),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .m_axis_tlast  (m_axis_tlast)
   );

endmodule

// ==== hw/axis_downsizer.sv ====
////////////////////////////////////////////////////////////////////////////
// Execute stage: slices 256-bit words into 64-bit beats, places tlast
// and attaches the metadata word to the first beat of each packet
////////////////////////////////////////////////////////////////////////////

`include "axis_conv_params.svh"

module axis_downsizer (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,
   // Input FIFO head
   input  axis_conv_pkg::s_data_t  fifo_data,
   input  axis_conv_pkg::s_strb_t  fifo_strb,
   input  logic                    fifo_last,
   input  logic                    fifo_empty,
   output logic                    fifo_pop,
   // Length FIFO head
   input  axis_conv_pkg::pkt_len_t meta_len,
   input  logic                    meta_empty,
   output logic                    meta_pop,
   // Master stream
   output axis_conv_pkg::m_data_t  m_axis_tdata,
   output axis_conv_pkg::m_strb_t  m_axis_tstrb,
   output axis_conv_pkg::user_t    m_axis_tuser,
   output logic                    m_axis_tvalid,
   input  logic                    m_axis_tready,
   output logic                    m_axis_tlast
);

   localparam int SLICES = `AXC_S_DATA_W / `AXC_M_DATA_W;
   localparam int M_BYTES = `AXC_M_DATA_W / 8;

   axis_conv_pkg::ds_state_t  state;
   axis_conv_pkg::slice_idx_t slice_idx;
   axis_conv_pkg::slice_idx_t final_idx;  // Last slice to emit from this word
   axis_conv_pkg::user_t      meta_word;
   logic                      beat_acc;
   logic                      beat_final;

   ////////////////////////////////////////////////////////////////////////////
   // Slice selection
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      final_idx = axis_conv_pkg::slice_idx_t'(SLICES - 1);
      if (fifo_last) begin
         final_idx = '0;
         for (int s = 0; s < SLICES; s++) begin
            if (|fifo_strb[s*M_BYTES +: M_BYTES]) begin
               final_idx = axis_conv_pkg::slice_idx_t'(s);
            end
         end
      end
   end

   // Metadata word
   always_comb begin
      meta_word = '0;
      meta_word[`AXC_LEN_W-1:0]    = meta_len;
      meta_word[`AXC_LEN_W +: 8]   = `AXC_DEF_SRC_PORT;
      meta_word[`AXC_LEN_W+8 +: 8] = `AXC_DEF_DST_PORT;
   end

   assign beat_final = (slice_idx == final_idx);
   assign beat_acc   = m_axis_tvalid & m_axis_tready;

   // First beat also needs its length
   assign m_axis_tvalid = ~fifo_empty & ((state == axis_conv_pkg::STREAM) | ~meta_empty);
   assign m_axis_tdata  = fifo_data[slice_idx*`AXC_M_DATA_W +: `AXC_M_DATA_W];
   assign m_axis_tstrb  = fifo_strb[slice_idx*M_BYTES +: M_BYTES];
   assign m_axis_tlast  = fifo_last & beat_final;
   assign m_axis_tuser  = (state == axis_conv_pkg::WAIT_META) ? meta_word : '0;

   assign fifo_pop = beat_acc & beat_final;                          // Word used up
   assign meta_pop = beat_acc & (state == axis_conv_pkg::WAIT_META);

   ////////////////////////////////////////////////////////////////////////////
   // FSM and slice counter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= axis_conv_pkg::WAIT_META;
         slice_idx <= '0;
      end else if (beat_acc) begin
         if (beat_final) begin
            slice_idx <= '0;
            state     <= fifo_last ? axis_conv_pkg::WAIT_META : axis_conv_pkg::STREAM;
         end else begin
            slice_idx <= slice_idx + 2'd1;
            state     <= axis_conv_pkg::STREAM;
         end
      end
   end

endmodule

// ==== hw/axis_len_tagger.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode stage: sums strobe bytes per packet and queues each length
////////////////////////////////////////////////////////////////////////////

`include "axis_conv_params.svh"

module axis_len_tagger (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,
   input  logic                    word_acc,
   input  axis_conv_pkg::s_strb_t  s_axis_tstrb,
   input  logic                    s_axis_tlast,
   input  logic                    meta_pop,
   output axis_conv_pkg::pkt_len_t meta_len,
   output logic                    meta_empty,
   output logic                    meta_full
);

   axis_conv_pkg::pkt_len_t run_sum;     // Bytes of the packet so far
   axis_conv_pkg::pkt_len_t word_bytes;
   axis_conv_pkg::pkt_len_t pkt_len;
   logic                    len_push;

   // Strobes are contiguous from byte 0, so the top set bit gives the count
   always_comb begin
      word_bytes = '0;
      for (int i = 0; i < `AXC_S_DATA_W/8; i++) begin
         if (s_axis_tstrb[i]) begin
            word_bytes = axis_conv_pkg::pkt_len_t'(i + 1);
         end
      end
   end

   assign pkt_len  = run_sum + word_bytes;
   assign len_push = word_acc & s_axis_tlast;  // One length per packet

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         run_sum <= '0;
      end else if (word_acc) begin
         run_sum <= s_axis_tlast ? '0 : pkt_len;  // Restart on packet end
      end
   end

   axis_fallthrough_fifo #(
      .WIDTH  (`AXC_LEN_W),
      .ADDR_W (`AXC_INFO_FIFO_AW)
   ) len_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (len_push),
      .din         (pkt_len),
      .rd_en       (meta_pop),
      .dout        (meta_len),
      .empty       (meta_empty),
      .nearly_full (meta_full)
   );

endmodule

// ==== hw/axis_fallthrough_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// First-word-fall-through FIFO with empty and nearly-full flags
////////////////////////////////////////////////////////////////////////////

module axis_fallthrough_fifo #(
   parameter int WIDTH  = 8,
   parameter int ADDR_W = 4
) (
   input  logic             axi_aclk,
   input  logic             axi_resetn,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             nearly_full
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [WIDTH-1:0]  mem [DEPTH];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [ADDR_W:0]   count;    // True occupancy
   logic [ADDR_W:0]   avail;    // Words the reader may see
   logic              wr_seen;  // Write of the last edge, shown one cycle late
   logic              rd_ok;

   assign rd_ok = rd_en & ~empty;

   // Storage
   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         avail   <= '0;
         wr_seen <= 1'b0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
         count   <= count + (ADDR_W+1)'(wr_en) - (ADDR_W+1)'(rd_ok);
         avail   <= avail + (ADDR_W+1)'(wr_seen) - (ADDR_W+1)'(rd_ok);
         wr_seen <= wr_en;
      end
   end

   assign dout        = mem[rd_ptr];  // Head presented without a read cycle
   assign empty       = (avail == '0);
   assign nearly_full = (count >= (ADDR_W+1)'(DEPTH - 4));  // Four entries of margin

endmodule

// ==== hw/axis_conv_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the stream width converter
////////////////////////////////////////////////////////////////////////////

`include "axis_conv_params.svh"

package axis_conv_pkg;

   // Slave side
   typedef logic [`AXC_S_DATA_W-1:0]   s_data_t;
   typedef logic [`AXC_S_DATA_W/8-1:0] s_strb_t;

   // Master side
   typedef logic [`AXC_M_DATA_W-1:0]   m_data_t;
   typedef logic [`AXC_M_DATA_W/8-1:0] m_strb_t;

   // Low to high: length, src port, dst port, zeros
   typedef logic [`AXC_USER_W-1:0]     user_t;

   typedef logic [`AXC_LEN_W-1:0]      pkt_len_t;
   typedef logic [1:0]                 slice_idx_t;  // 64-bit slice of a 256-bit word

   typedef enum logic {
      WAIT_META,  // Next beat opens a packet
      STREAM
   } ds_state_t;

endpackage

// ==== hw/axis_conv_params.svh ====
////////////////////////////////////////////////////////////////////////////
// Stream converter widths, FIFO depths and default metadata ports
////////////////////////////////////////////////////////////////////////////

`ifndef AXIS_CONV_PARAMS_SVH
`define AXIS_CONV_PARAMS_SVH

// Stream widths
`define AXC_S_DATA_W      256   // Slave word
`define AXC_M_DATA_W      64    // Master word
`define AXC_USER_W        128   // Metadata word
`define AXC_LEN_W         16    // Packet length in bytes

// FIFO address bits
`define AXC_IN_FIFO_AW    6     // 64 words, one 1600-byte packet with margin
`define AXC_INFO_FIFO_AW  5     // 32 lengths

// Default metadata ports
`define AXC_DEF_SRC_PORT  8'd1
`define AXC_DEF_DST_PORT  8'd2

`endif
